//--- src/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // serial timing, one fixed rate
  localparam int clks_per_bit = 16;
  localparam int half_bit = clks_per_bit / 2;

  // start, 8 data, odd parity, stop
  localparam int frame_bits = 11;

  // bit periods a read waits for the reply start bit
  localparam int reply_timeout_bits = 40;

  localparam bit parity_check = 1'b1;

  // command layout
  localparam int cmd_rw_bit = 15;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] cmd_t;
  typedef logic [3:0] bit_cnt_t;
  typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;
  typedef logic [$clog2(reply_timeout_bits + 1)-1:0] timeout_cnt_t;

  typedef struct packed {
    byte_t data;
    logic  parity_err;
    logic  timeout;
  } read_result_t;

  typedef struct packed {
    byte_t data;
    logic  parity_err;
  } rx_frame_t;

  typedef enum logic [2:0] {
    idle,
    send_hi,
    send_lo,
    wait_reply,
    deliver
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            tx_start,
  input  wire uart_pkg::byte_t tx_byte,
  output logic                 tx_busy,
  output logic                 tx
);

  logic [uart_pkg::frame_bits-1:0] shift_q;
  uart_pkg::baud_cnt_t baud_cnt;
  uart_pkg::bit_cnt_t bit_cnt;
  logic bit_end;
  logic last_bit;

  assign bit_end = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit - 1));
  assign last_bit = (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::frame_bits - 1));

  // line is the low end of the shift register
  assign tx = shift_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '1;
      tx_busy <= 1'b0;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end else if (tx_start) begin
      // stop, odd parity, data lsb first, start
      shift_q <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      tx_busy <= 1'b1;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end else if (tx_busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        shift_q <= {1'b1, shift_q[uart_pkg::frame_bits-1:1]};
        if (last_bit) begin
          tx_busy <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                rx,
  output logic                     rx_active,
  output logic                     rx_valid,
  output uart_pkg::rx_frame_t      rx_frame
);

  localparam uart_pkg::bit_cnt_t parity_idx = uart_pkg::bit_cnt_t'(9);
  localparam uart_pkg::bit_cnt_t stop_idx = uart_pkg::bit_cnt_t'(uart_pkg::frame_bits - 1);

  logic rx_s1;
  logic rx_s2;
  logic rx_prev;
  logic fall;
  logic mid_bit;
  logic bit_end;
  logic parity_bad;
  uart_pkg::baud_cnt_t baud_cnt;
  uart_pkg::bit_cnt_t bit_cnt;
  uart_pkg::byte_t data_q;
  logic parity_q;

  assign fall = rx_prev && !rx_s2;
  assign mid_bit = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::half_bit - 1));
  assign bit_end = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit - 1));
  assign parity_bad = uart_pkg::parity_check && (parity_q != ~^data_q);

  // two-flop synchronizer plus edge history, line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_active <= 1'b0;
      rx_valid <= 1'b0;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!rx_active) begin
        if (fall) begin
          rx_active <= 1'b1;
          baud_cnt <= '0;
          bit_cnt <= '0;
        end
      end else begin
        if (bit_end) begin
          baud_cnt <= '0;
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
        if (mid_bit) begin
          bit_cnt <= bit_cnt + 1'b1;
          // glitch, start bit gone by mid-period
          if (bit_cnt == '0 && rx_s2) begin
            rx_active <= 1'b0;
          end
          if (bit_cnt == stop_idx) begin
            rx_active <= 1'b0;
            rx_valid <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_active && mid_bit) begin
      if (bit_cnt != '0 && bit_cnt < parity_idx) begin
        data_q <= {rx_s2, data_q[7:1]};
      end
      if (bit_cnt == parity_idx) begin
        parity_q <= rx_s2;
      end
      if (bit_cnt == stop_idx) begin
        rx_frame.data <= data_q;
        // a low stop bit counts as a framing fault
        rx_frame.parity_err <= parity_bad || !rx_s2;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/uart_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire uart_pkg::cmd_t       cmd_in,
  input  wire logic                 cmd_vld,
  output logic                      cmd_rdy,
  output logic                      tx_start,
  output uart_pkg::byte_t           tx_byte,
  input  wire logic                 tx_busy,
  input  wire logic                 rx_active,
  input  wire logic                 rx_valid,
  input  wire uart_pkg::rx_frame_t  rx_frame,
  output logic                      read_rdy,
  output uart_pkg::read_result_t    read_data
);

  uart_pkg::ctrl_state_t state;
  uart_pkg::baud_cnt_t tmo_baud;
  uart_pkg::timeout_cnt_t tmo_bits;
  uart_pkg::byte_t lo_q;
  logic write_q;
  logic accept;
  logic frame_done;
  logic tmo_tick;
  logic tmo_expired;

  // result cycle doubles as the next accept slot
  assign cmd_rdy = (state == uart_pkg::idle) || (state == uart_pkg::deliver);
  assign accept = cmd_vld && cmd_rdy;
  assign read_rdy = (state == uart_pkg::deliver);

  // start pulse still in flight means busy has not risen yet
  assign frame_done = !tx_start && !tx_busy;

  assign tmo_tick = (tmo_baud == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit - 1));
  assign tmo_expired = (tmo_bits == uart_pkg::timeout_cnt_t'(uart_pkg::reply_timeout_bits));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::idle;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        uart_pkg::idle, uart_pkg::deliver: begin
          if (accept) begin
            state <= uart_pkg::send_hi;
            tx_start <= 1'b1;
          end else begin
            state <= uart_pkg::idle;
          end
        end
        uart_pkg::send_hi: begin
          if (frame_done) begin
            if (write_q) begin
              state <= uart_pkg::send_lo;
              tx_start <= 1'b1;
            end else begin
              state <= uart_pkg::wait_reply;
            end
          end
        end
        uart_pkg::send_lo: begin
          if (frame_done) begin
            state <= uart_pkg::idle;
          end
        end
        uart_pkg::wait_reply: begin
          if (rx_valid || tmo_expired) begin
            state <= uart_pkg::deliver;
          end
        end
        default: state <= uart_pkg::idle;
      endcase
    end
  end

  // bit periods since the request frame ended, paused during a reply
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tmo_baud <= '0;
      tmo_bits <= '0;
    end else if (state != uart_pkg::wait_reply) begin
      tmo_baud <= '0;
      tmo_bits <= '0;
    end else if (!rx_active && !tmo_expired) begin
      if (tmo_tick) begin
        tmo_baud <= '0;
        tmo_bits <= tmo_bits + 1'b1;
      end else begin
        tmo_baud <= tmo_baud + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      write_q <= cmd_in[uart_pkg::cmd_rw_bit];
      lo_q <= cmd_in[7:0];
      tx_byte <= cmd_in[15:8];
    end else if (state == uart_pkg::send_hi && frame_done && write_q) begin
      tx_byte <= lo_q;
    end

    // replies outside wait_reply are dropped here
    if (state == uart_pkg::wait_reply) begin
      if (rx_valid) begin
        read_data.data <= rx_frame.data;
        read_data.parity_err <= rx_frame.parity_err;
        read_data.timeout <= 1'b0;
      end else if (tmo_expired) begin
        read_data.data <= '0;
        read_data.parity_err <= 1'b0;
        read_data.timeout <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bridge (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire uart_pkg::cmd_t       cmd_in,
  input  wire logic                 cmd_vld,
  output logic                      cmd_rdy,
  input  wire logic                 rx,
  output logic                      tx,
  output logic                      read_rdy,
  output uart_pkg::read_result_t    read_data
);

  logic tx_start;
  uart_pkg::byte_t tx_byte;
  logic tx_busy;
  logic rx_active;
  logic rx_valid;
  uart_pkg::rx_frame_t rx_frame;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_active (rx_active),
    .rx_valid  (rx_valid),
    .rx_frame  (rx_frame),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_active (rx_active),
    .rx_valid  (rx_valid),
    .rx_frame  (rx_frame)
  );

endmodule

`default_nettype wire

//--- test/uart_bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_checker (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic cmd_vld,
  input wire logic cmd_rdy,
  input wire logic tx,
  input wire logic read_rdy
);

  // busy right after a command is taken
  a_rdy_drops: assert property (
    @(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy
  ) else $error("cmd_rdy still high the cycle after an accepted command");

  a_read_rdy_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy
  ) else $error("read_rdy high for two cycles in a row");

  // no frame in flight while ready
  a_tx_idle: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx
  ) else $error("tx low while cmd_rdy is high");

endmodule

bind uart_bridge uart_bridge_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

`default_nettype wire

//--- test/tb_uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_bridge;

  localparam int num_cmds = 40;
  localparam int max_cycles = num_cmds * uart_pkg::clks_per_bit *
    (3 * uart_pkg::frame_bits + uart_pkg::reply_timeout_bits + 10);

  localparam logic [1:0] reply_ok = 2'd0;
  localparam logic [1:0] reply_bad_parity = 2'd1;
  localparam logic [1:0] reply_silent = 2'd2;

  typedef struct packed {
    uart_pkg::byte_t data;
    logic [1:0]      mode;
    logic [9:0]      delay;
  } reply_t;

  logic clk;
  logic rst_n;
  uart_pkg::cmd_t cmd_in;
  logic cmd_vld;
  logic cmd_rdy;
  logic rx;
  logic tx;
  logic read_rdy;
  uart_pkg::read_result_t read_data;

  integer seed;
  int cycle_cnt = 0;
  int frame_cnt = 0;
  int result_cnt = 0;
  int write_cnt = 0;
  int read_cnt = 0;
  logic reply_busy;
  uart_pkg::byte_t mem [128];
  uart_pkg::cmd_t pending_q [$];
  uart_pkg::read_result_t expect_q [$];
  reply_t reply_q [$];

  uart_bridge UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped on timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_on_fault(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", what);
  endtask

  // entered at the first falling clock edge that sees the start bit
  task automatic decode_frame(output uart_pkg::byte_t data);
    logic [uart_pkg::frame_bits-1:0] bits;
    repeat (uart_pkg::half_bit - 1) @(negedge clk);
    bits[0] = tx;
    for (int i = 1; i < uart_pkg::frame_bits; i++) begin
      repeat (uart_pkg::clks_per_bit) @(negedge clk);
      bits[i] = tx;
    end
    check_value("tx start bit", 32'(bits[0]), 32'd0);
    check_value("tx parity bit", 32'(bits[9]), 32'(~^bits[8:1]));
    check_value("tx stop bit", 32'(bits[10]), 32'd1);
    data = bits[8:1];
  endtask

  task automatic send_reply(input uart_pkg::byte_t data, input logic bad_parity);
    logic [uart_pkg::frame_bits-1:0] bits;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < uart_pkg::frame_bits; i++) begin
      rx = bits[i];
      repeat (uart_pkg::clks_per_bit) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  // holds cmd_vld until the bridge takes the command
  task automatic send_command(input uart_pkg::cmd_t cmd);
    cmd_in = cmd;
    cmd_vld = 1'b1;
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    pending_q.push_back(cmd);
    if (cmd[uart_pkg::cmd_rw_bit]) write_cnt++;
    else read_cnt++;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  // stray cmd_vld pulses only while cmd_rdy is low
  task automatic idle_gap(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (!cmd_rdy && ($unsigned($random(seed)) % 4 == 0)) begin
        cmd_in = uart_pkg::cmd_t'($random(seed));
        cmd_vld = 1'b1;
      end else begin
        cmd_vld = 1'b0;
      end
    end
  endtask

  // remote device, decodes tx and queues replies
  initial begin
    uart_pkg::byte_t hi;
    uart_pkg::byte_t lo;
    uart_pkg::cmd_t cmd;
    uart_pkg::read_result_t exp;
    reply_t r;
    int pick;
    forever begin
      @(negedge clk);
      if (rst_n && !tx) begin
        // counted at the start bit so a late stray frame still shows
        frame_cnt++;
        decode_frame(hi);
        if (pending_q.size() == 0) begin
          stop_on_fault("a frame was sent on tx without an accepted command");
        end else begin
          cmd = pending_q.pop_front();
          check_value("tx high byte", 32'(hi), 32'(cmd[15:8]));
          if (hi[7]) begin
            do @(negedge clk); while (tx);
            frame_cnt++;
            decode_frame(lo);
            check_value("tx low byte", 32'(lo), 32'(cmd[7:0]));
            mem[hi[6:0]] = lo;
          end else begin
            pick = $unsigned($random(seed)) % 8;
            r.data = mem[hi[6:0]];
            r.delay = 10'(uart_pkg::clks_per_bit + $unsigned($random(seed)) % 384);
            if (pick < 6) r.mode = reply_ok;
            else if (pick == 6) r.mode = reply_bad_parity;
            else r.mode = reply_silent;
            exp.data = (r.mode == reply_silent) ? 8'h00 : r.data;
            exp.parity_err = (r.mode == reply_bad_parity);
            exp.timeout = (r.mode == reply_silent);
            expect_q.push_back(exp);
            reply_q.push_back(r);
          end
        end
      end
    end
  end

  initial begin
    reply_t r;
    forever begin
      @(negedge clk);
      if (reply_q.size() > 0) begin
        reply_busy = 1'b1;
        r = reply_q.pop_front();
        repeat (r.delay) @(negedge clk);
        if (r.mode != reply_silent) begin
          send_reply(r.data, r.mode == reply_bad_parity);
        end
        reply_busy = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && read_rdy) begin
      if (expect_q.size() == 0) begin
        stop_on_fault("read_rdy pulsed with no read outstanding");
      end else begin
        check_value("read_data", 32'(read_data), 32'(expect_q.pop_front()));
        result_cnt++;
      end
    end
  end

  initial begin
    uart_pkg::cmd_t cmd;
    int gap;
    seed = 81;
    clk = 1'b0;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    reply_busy = 1'b0;
    for (int a = 0; a < 128; a++) begin
      mem[a] = uart_pkg::byte_t'(a * 37) ^ 8'ha5;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("tx", 32'(tx), 32'd1);
    check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);
    check_value("read_rdy", 32'(read_rdy), 32'd0);

    for (int n = 0; n < num_cmds; n++) begin
      gap = $unsigned($random(seed)) % 24;
      idle_gap(gap);
      cmd = uart_pkg::cmd_t'($random(seed));
      send_command(cmd);
    end

    // drain, then a quiet stretch to catch stray frames or results
    do @(negedge clk);
    while (reply_q.size() != 0 || reply_busy || !cmd_rdy);
    repeat (4 * uart_pkg::clks_per_bit) @(negedge clk);

    check_value("frame count", 32'(frame_cnt), 32'(2 * write_cnt + read_cnt));
    check_value("result count", 32'(result_cnt), 32'(read_cnt));
    check_value("tx", 32'(tx), 32'd1);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_cmd_ctrl.sv
src/uart_bridge.sv
test/uart_bridge_checker.sv
test/tb_uart_bridge.sv

//--- Makefile
# Verilator flow for the UART command bridge

VERILATOR  ?= verilator
TOP        ?= tb_uart_bridge
DUT_TOP    ?= uart_bridge
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= *** TEST PASSED ***
FAIL_MSG   ?= *** TEST FAILED ***

SOURCES := $(shell cat $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint lint_dut sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

lint_dut:
	$(VERILATOR) --lint-only -Wall --top-module $(DUT_TOP) \
		src/uart_pkg.sv src/uart_tx.sv src/uart_rx.sv \
		src/uart_cmd_ctrl.sv src/uart_bridge.sv

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
